//--- rtl/priv_macros.svh
// Trap unit constants
// Data width, CSR addresses, cause codes and status bit positions
`ifndef PRIV_MACROS_SVH
`define PRIV_MACROS_SVH

`define PRIV_XLEN 32

// Machine-mode CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MTVAL   12'h343
`define CSR_MIP     12'h344

// Exception cause codes
`define EX_INSN_MAL    4'd0
`define EX_INSN_ACCESS 4'd1
`define EX_ILLEGAL     4'd2
`define EX_BREAKPOINT  4'd3
`define EX_L_MAL       4'd4
`define EX_L_FAULT     4'd5
`define EX_S_MAL       4'd6
`define EX_S_FAULT     4'd7
`define EX_ENV_U       4'd8
`define EX_ENV_M       4'd11

// Interrupt cause codes
`define INT_SOFT_M  4'd3
`define INT_TIMER_M 4'd7
`define INT_EXT_M   4'd11

// Bit positions in mstatus, and in mip and mie alike
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MSTATUS_MPP  12:11
`define MIP_MSIP     3
`define MIP_MTIP     7
`define MIP_MEIP     11

`endif

//--- rtl/priv_pkg.sv
// Trap unit types
// Data word, CSR address, cause code and privilege level
`default_nettype none
`include "priv_macros.svh"

package priv_pkg;

    // One machine word
    typedef logic [`PRIV_XLEN-1:0] word_t;

    // 12-bit CSR address space
    typedef logic [11:0] csr_addr_t;

    // Cause code as stored in the low bits of mcause
    typedef logic [3:0] cause_t;

    // Only user and machine mode exist
    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        M_MODE = 2'b11
    } priv_level_t;

endpackage

`default_nettype wire

//--- rtl/priv_int_ex_handler.sv
// Machine-mode interrupt and exception handler
// Ranks trap sources and computes the next CSR values with their strobes
`timescale 1ns/1ps
`default_nettype none
`include "priv_macros.svh"

module priv_int_ex_handler (
    input  wire                   breakpoint,
    input  wire                   fault_insn_access,
    input  wire                   illegal_insn,
    input  wire                   mal_insn,
    input  wire                   ecall,
    input  wire                   mal_s,
    input  wire                   mal_l,
    input  wire                   fault_s,
    input  wire                   fault_l,
    input  wire                   mret,
    input  wire                   ext_int,
    input  wire                   soft_int,
    input  wire                   timer_int,
    input  wire                   clear_ext_int,
    input  wire                   clear_soft_int,
    input  wire                   clear_timer_int,
    input  wire priv_pkg::word_t  epc,
    input  wire priv_pkg::word_t  badaddr,
    input  wire priv_pkg::word_t  curr_mstatus,
    input  wire priv_pkg::word_t  curr_mie,
    input  wire priv_pkg::word_t  curr_mip,
    input  wire priv_pkg::priv_level_t curr_priv,
    output logic                  trap,
    output logic                  inject_mstatus,
    output logic                  inject_mip,
    output logic                  inject_mepc,
    output logic                  inject_mcause,
    output logic                  inject_mtval,
    output logic                  inject_priv,
    output priv_pkg::word_t       next_mstatus,
    output priv_pkg::word_t       next_mip,
    output priv_pkg::word_t       next_mepc,
    output priv_pkg::word_t       next_mcause,
    output priv_pkg::word_t       next_mtval,
    output priv_pkg::priv_level_t next_priv
);

    logic             exception;
    logic             ex_is_ecall;
    priv_pkg::cause_t ex_cause;
    logic             ext_pending;
    logic             soft_pending;
    logic             timer_pending;
    logic             interrupt_fired;
    priv_pkg::cause_t int_cause;

    // Fixed exception priority, first match wins
    always_comb begin
        exception   = 1'b1;
        ex_is_ecall = 1'b0;
        ex_cause    = `EX_INSN_MAL;
        if (breakpoint)             ex_cause = `EX_BREAKPOINT;
        else if (fault_insn_access) ex_cause = `EX_INSN_ACCESS;
        else if (illegal_insn)      ex_cause = `EX_ILLEGAL;
        else if (mal_insn)          ex_cause = `EX_INSN_MAL;
        else if (ecall) begin
            ex_is_ecall = 1'b1;
            ex_cause    = (curr_priv == priv_pkg::M_MODE) ? `EX_ENV_M : `EX_ENV_U;
        end
        else if (mal_s)             ex_cause = `EX_S_MAL;
        else if (mal_l)             ex_cause = `EX_L_MAL;
        else if (fault_s)           ex_cause = `EX_S_FAULT;
        else if (fault_l)           ex_cause = `EX_L_FAULT;
        else                        exception = 1'b0;
    end

    // Pending and enabled, gated globally by mstatus.mie
    assign ext_pending   = curr_mie[`MIP_MEIP] & curr_mip[`MIP_MEIP];
    assign soft_pending  = curr_mie[`MIP_MSIP] & curr_mip[`MIP_MSIP];
    assign timer_pending = curr_mie[`MIP_MTIP] & curr_mip[`MIP_MTIP];
    assign interrupt_fired = curr_mstatus[`MSTATUS_MIE]
                           & (ext_pending | soft_pending | timer_pending);

    always_comb begin
        if (ext_pending)       int_cause = `INT_EXT_M;
        else if (soft_pending) int_cause = `INT_SOFT_M;
        else                   int_cause = `INT_TIMER_M;
    end

    assign trap = exception | interrupt_fired;

    // Exceptions outrank interrupts; top bit flags an interrupt
    assign inject_mcause = trap;
    assign next_mcause   = {~exception, {(`PRIV_XLEN-5){1'b0}},
                            exception ? ex_cause : int_cause};

    assign inject_mepc = trap;
    assign next_mepc   = epc;

    // ecall has no faulting address
    assign inject_mtval = exception & ~ex_is_ecall;
    assign next_mtval   = badaddr;

    // Set wins over clear for each pending bit
    assign inject_mip = ext_int | soft_int | timer_int
                      | clear_ext_int | clear_soft_int | clear_timer_int;
    always_comb begin
        next_mip = curr_mip;
        if (ext_int)              next_mip[`MIP_MEIP] = 1'b1;
        else if (clear_ext_int)   next_mip[`MIP_MEIP] = 1'b0;
        if (soft_int)             next_mip[`MIP_MSIP] = 1'b1;
        else if (clear_soft_int)  next_mip[`MIP_MSIP] = 1'b0;
        if (timer_int)            next_mip[`MIP_MTIP] = 1'b1;
        else if (clear_timer_int) next_mip[`MIP_MTIP] = 1'b0;
    end

    // Trap entry stacks mie and privilege, mret unwinds them
    assign inject_mstatus = trap | mret;
    assign inject_priv    = trap | mret;
    always_comb begin
        next_mstatus = curr_mstatus;
        next_priv    = priv_pkg::M_MODE;
        if (trap) begin
            next_mstatus[`MSTATUS_MPIE] = curr_mstatus[`MSTATUS_MIE];
            next_mstatus[`MSTATUS_MIE]  = 1'b0;
            next_mstatus[`MSTATUS_MPP]  = curr_priv;
        end else if (mret) begin
            next_mstatus[`MSTATUS_MIE]  = curr_mstatus[`MSTATUS_MPIE];
            next_mstatus[`MSTATUS_MPIE] = 1'b0;
            next_mstatus[`MSTATUS_MPP]  = priv_pkg::U_MODE;
            // Reserved mpp encodings fall back to U
            if (curr_mstatus[`MSTATUS_MPP] != priv_pkg::M_MODE)
                next_priv = priv_pkg::U_MODE;
        end
    end

    // Pipeline must not retire mret in a cycle that traps
    always_comb begin
        assert (!(trap && mret))
            else $error("trap and mret asserted together");
    end

endmodule

`default_nettype wire

//--- rtl/priv_csr_regs.sv
// Machine-mode CSR storage with an APB slave port
// Hardware injects from the handler win over APB writes
`timescale 1ns/1ps
`default_nettype none
`include "priv_macros.svh"

module priv_csr_regs (
    input  wire                        CLK,
    input  wire                        rst_n,
    // APB slave
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire priv_pkg::csr_addr_t   paddr,
    input  wire priv_pkg::word_t       pwdata,
    output priv_pkg::word_t            prdata,
    output logic                       pready,
    output logic                       pslverr,
    // Hardware updates
    input  wire                        inject_mstatus,
    input  wire                        inject_mip,
    input  wire                        inject_mepc,
    input  wire                        inject_mcause,
    input  wire                        inject_mtval,
    input  wire                        inject_priv,
    input  wire priv_pkg::word_t       next_mstatus,
    input  wire priv_pkg::word_t       next_mip,
    input  wire priv_pkg::word_t       next_mepc,
    input  wire priv_pkg::word_t       next_mcause,
    input  wire priv_pkg::word_t       next_mtval,
    input  wire priv_pkg::priv_level_t next_priv,
    // Current state
    output priv_pkg::word_t            curr_mstatus,
    output priv_pkg::word_t            curr_mie,
    output priv_pkg::word_t            curr_mip,
    output priv_pkg::priv_level_t      curr_priv,
    output priv_pkg::word_t            trap_vector,
    output priv_pkg::word_t            mret_target
);

    priv_pkg::word_t       mstatus;
    priv_pkg::word_t       mie;
    priv_pkg::word_t       mip;
    priv_pkg::word_t       mtvec;
    priv_pkg::word_t       mepc;
    priv_pkg::word_t       mcause;
    priv_pkg::word_t       mtval;
    priv_pkg::priv_level_t priv;

    logic            apb_access;
    logic            apb_write;
    logic            addr_hit;
    priv_pkg::word_t rd_value;

    // Zero wait states
    assign pready     = 1'b1;
    assign apb_access = psel & penable;

    // Address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        rd_value = '0;
        case (paddr)
            `CSR_MSTATUS: rd_value = mstatus;
            `CSR_MIE:     rd_value = mie;
            `CSR_MTVEC:   rd_value = mtvec;
            `CSR_MEPC:    rd_value = mepc;
            `CSR_MCAUSE:  rd_value = mcause;
            `CSR_MTVAL:   rd_value = mtval;
            `CSR_MIP:     rd_value = mip;
            default:      addr_hit = 1'b0;
        endcase
    end

    assign apb_write = apb_access & pwrite & addr_hit;
    assign prdata    = (apb_access && addr_hit) ? rd_value : '0;
    assign pslverr   = apb_access & ~addr_hit;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mstatus <= '0;
            mie     <= '0;
            mip     <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mtval   <= '0;
            priv    <= priv_pkg::M_MODE;
        end else begin
            // Only mie, mpie and mpp are implemented in mstatus
            if (inject_mstatus) begin
                mstatus <= next_mstatus;
            end else if (apb_write && paddr == `CSR_MSTATUS) begin
                mstatus[`MSTATUS_MIE]  <= pwdata[`MSTATUS_MIE];
                mstatus[`MSTATUS_MPIE] <= pwdata[`MSTATUS_MPIE];
                mstatus[`MSTATUS_MPP]  <= pwdata[`MSTATUS_MPP];
            end

            if (apb_write && paddr == `CSR_MIE) begin
                mie[`MIP_MSIP] <= pwdata[`MIP_MSIP];
                mie[`MIP_MTIP] <= pwdata[`MIP_MTIP];
                mie[`MIP_MEIP] <= pwdata[`MIP_MEIP];
            end

            // mip is read-only from the bus
            if (inject_mip)
                mip <= next_mip;

            if (apb_write && paddr == `CSR_MTVEC)
                mtvec <= pwdata;

            if (inject_mepc)
                mepc <= next_mepc;
            else if (apb_write && paddr == `CSR_MEPC)
                mepc <= pwdata;

            if (inject_mcause)
                mcause <= next_mcause;
            else if (apb_write && paddr == `CSR_MCAUSE)
                mcause <= pwdata;

            if (inject_mtval)
                mtval <= next_mtval;
            else if (apb_write && paddr == `CSR_MTVAL)
                mtval <= pwdata;

            if (inject_priv)
                priv <= next_priv;
        end
    end

    assign curr_mstatus = mstatus;
    assign curr_mie     = mie;
    assign curr_mip     = mip;
    assign curr_priv    = priv;

    // Direct mode only, so the mode bits never reach the PC
    assign trap_vector = {mtvec[`PRIV_XLEN-1:2], 2'b00};
    assign mret_target = mepc;

    // APB protocol checks on the slave side
    penable_needs_psel: assert property (
        @(posedge CLK) disable iff (!rst_n) penable |-> psel
    ) else $error("penable high without psel");

    paddr_stable: assert property (
        @(posedge CLK) disable iff (!rst_n) (psel && !penable) |=> $stable(paddr)
    ) else $error("paddr changed between setup and access phase");

endmodule

`default_nettype wire

//--- rtl/priv_trap_unit.sv
// Machine-mode trap unit top level
// Joins the trap handler and the CSR block to the pipeline and APB
`timescale 1ns/1ps
`default_nettype none

module priv_trap_unit (
    input  wire                        CLK,
    input  wire                        rst_n,
    // Pipeline events
    input  wire                        breakpoint,
    input  wire                        fault_insn_access,
    input  wire                        illegal_insn,
    input  wire                        mal_insn,
    input  wire                        ecall,
    input  wire                        mal_s,
    input  wire                        mal_l,
    input  wire                        fault_s,
    input  wire                        fault_l,
    input  wire                        mret,
    input  wire                        ext_int,
    input  wire                        soft_int,
    input  wire                        timer_int,
    input  wire                        clear_ext_int,
    input  wire                        clear_soft_int,
    input  wire                        clear_timer_int,
    input  wire priv_pkg::word_t       epc,
    input  wire priv_pkg::word_t       badaddr,
    // APB slave
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire priv_pkg::csr_addr_t   paddr,
    input  wire priv_pkg::word_t       pwdata,
    output priv_pkg::word_t            prdata,
    output logic                       pready,
    output logic                       pslverr,
    // Back to the pipeline
    output logic                       trap,
    output priv_pkg::word_t            trap_vector,
    output priv_pkg::word_t            mret_target,
    output priv_pkg::priv_level_t      priv_level
);

    logic inject_mstatus, inject_mip, inject_mepc;
    logic inject_mcause, inject_mtval, inject_priv;
    priv_pkg::word_t next_mstatus, next_mip, next_mepc, next_mcause, next_mtval;
    priv_pkg::word_t curr_mstatus, curr_mie, curr_mip;
    priv_pkg::priv_level_t next_priv;

    priv_int_ex_handler handler_inst (
        .breakpoint(breakpoint), .fault_insn_access(fault_insn_access),
        .illegal_insn(illegal_insn), .mal_insn(mal_insn), .ecall(ecall),
        .mal_s(mal_s), .mal_l(mal_l), .fault_s(fault_s), .fault_l(fault_l),
        .mret(mret), .ext_int(ext_int), .soft_int(soft_int), .timer_int(timer_int),
        .clear_ext_int(clear_ext_int), .clear_soft_int(clear_soft_int),
        .clear_timer_int(clear_timer_int), .epc(epc), .badaddr(badaddr),
        .curr_mstatus(curr_mstatus), .curr_mie(curr_mie), .curr_mip(curr_mip),
        .curr_priv(priv_level), .trap(trap),
        .inject_mstatus(inject_mstatus), .inject_mip(inject_mip),
        .inject_mepc(inject_mepc), .inject_mcause(inject_mcause),
        .inject_mtval(inject_mtval), .inject_priv(inject_priv),
        .next_mstatus(next_mstatus), .next_mip(next_mip), .next_mepc(next_mepc),
        .next_mcause(next_mcause), .next_mtval(next_mtval), .next_priv(next_priv)
    );

    priv_csr_regs csr_inst (
        .CLK(CLK), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .inject_mstatus(inject_mstatus), .inject_mip(inject_mip),
        .inject_mepc(inject_mepc), .inject_mcause(inject_mcause),
        .inject_mtval(inject_mtval), .inject_priv(inject_priv),
        .next_mstatus(next_mstatus), .next_mip(next_mip), .next_mepc(next_mepc),
        .next_mcause(next_mcause), .next_mtval(next_mtval), .next_priv(next_priv),
        .curr_mstatus(curr_mstatus), .curr_mie(curr_mie), .curr_mip(curr_mip),
        .curr_priv(priv_level), .trap_vector(trap_vector), .mret_target(mret_target)
    );

endmodule

`default_nettype wire

//--- test/priv_trap_unit_tb.sv
// Testbench for the machine-mode trap unit
// Directed tests over APB, exception ranking, interrupts and mret
`timescale 1ns/1ps
`default_nettype none
`include "priv_macros.svh"

module priv_trap_unit_tb;

    localparam int CYCLE_LIMIT = 2000;
    localparam int MPP_LSB     = 11;

    // Pipeline event bits, in port order of the DUT
    localparam int EV_BREAKPOINT = 0;
    localparam int EV_ILLEGAL    = 2;
    localparam int EV_ECALL      = 4;
    localparam int EV_MAL_S      = 5;
    localparam int EV_FAULT_L    = 8;
    localparam int EV_MRET       = 9;

    // Interrupt set and clear bits
    localparam int IRQ_EXT       = 0;
    localparam int IRQ_TIMER     = 2;
    localparam int IRQ_CLR_EXT   = 3;
    localparam int IRQ_CLR_TIMER = 5;

    logic        CLK;
    logic        rst_n;
    logic [9:0]  events;
    logic [5:0]  irq_lines;
    logic [31:0] epc;
    logic [31:0] badaddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    priv_pkg::word_t       prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  trap;
    priv_pkg::word_t       trap_vector;
    priv_pkg::word_t       mret_target;
    priv_pkg::priv_level_t priv_level;

    integer seed;
    int     error_count;
    int     check_count;
    int     test_count;
    int     cycles;

    priv_trap_unit priv_trap_unit_inst (
        .CLK(CLK), .rst_n(rst_n),
        .breakpoint(events[0]), .fault_insn_access(events[1]),
        .illegal_insn(events[2]), .mal_insn(events[3]), .ecall(events[4]),
        .mal_s(events[5]), .mal_l(events[6]), .fault_s(events[7]),
        .fault_l(events[8]), .mret(events[9]),
        .ext_int(irq_lines[0]), .soft_int(irq_lines[1]), .timer_int(irq_lines[2]),
        .clear_ext_int(irq_lines[3]), .clear_soft_int(irq_lines[4]),
        .clear_timer_int(irq_lines[5]), .epc(epc), .badaddr(badaddr),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .trap(trap), .trap_vector(trap_vector), .mret_target(mret_target),
        .priv_level(priv_level)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Run limit, far beyond the length of all tests
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not complete", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge CLK);
        penable <= 1'b1;
        // Write lands on the edge that ends the access phase
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        data = prdata;
        err  = pslverr;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // One-cycle pipeline event; trap is sampled mid-cycle
    task automatic pulse_event(input logic [9:0] lines, input logic [31:0] pc,
                               input logic [31:0] addr, output logic trap_seen);
        @(posedge CLK);
        events  <= lines;
        epc     <= pc;
        badaddr <= addr;
        @(negedge CLK);
        trap_seen = trap;
        @(posedge CLK);
        events <= '0;
        // CSR and privilege updates from the event are settled by the falling edge
        @(negedge CLK);
    endtask

    task automatic pulse_irq(input logic [5:0] lines);
        @(posedge CLK);
        irq_lines <= lines;
        @(posedge CLK);
        irq_lines <= '0;
    endtask

    task automatic wait_trap(input int max_cycles, input string what);
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!trap && n < max_cycles);
        if (!trap) begin
            error_count++;
            $display("No trap for %s within %0d cycles at %0t ns", what, max_cycles, $time);
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("Test %s finished, %0d errors so far", name, error_count);
    endtask

    task automatic reset_and_apb;
        logic [31:0] data;
        logic        err;
        logic [31:0] vec;
        vec = $random(seed);
        check_value("priv_level", {30'd0, priv_level}, 32'd3);
        check_value("pready", {31'd0, pready}, 32'd1);
        apb_read(`CSR_MSTATUS, data, err);
        check_value("mstatus", data, 32'd0);
        check_value("pslverr", {31'd0, err}, 32'd0);
        apb_read(`CSR_MIE, data, err);
        check_value("mie", data, 32'd0);
        apb_read(`CSR_MCAUSE, data, err);
        check_value("mcause", data, 32'd0);
        apb_write(`CSR_MTVEC, vec);
        apb_read(`CSR_MTVEC, data, err);
        check_value("mtvec", data, vec);
        check_value("trap_vector", trap_vector, vec & ~32'h3);
        apb_read(12'h7c0, data, err);
        check_value("pslverr", {31'd0, err}, 32'd1);
        check_value("prdata", data, 32'd0);
        report_test("reset_and_apb");
    endtask

    task automatic exception_priority;
        logic [31:0] data;
        logic        err;
        logic        seen;
        logic [31:0] pc;
        logic [31:0] addr;
        pc   = $random(seed);
        addr = $random(seed);
        // Global enable on, but no interrupt source enabled
        apb_write(`CSR_MSTATUS, 32'd1 << `MSTATUS_MIE);
        pulse_event((10'b1 << EV_ILLEGAL) | (10'b1 << EV_MAL_S) | (10'b1 << EV_FAULT_L),
                    pc, addr, seen);
        check_value("trap", {31'd0, seen}, 32'd1);
        apb_read(`CSR_MCAUSE, data, err);
        check_value("mcause", data, {28'd0, `EX_ILLEGAL});
        apb_read(`CSR_MEPC, data, err);
        check_value("mepc", data, pc);
        apb_read(`CSR_MTVAL, data, err);
        check_value("mtval", data, addr);
        apb_read(`CSR_MSTATUS, data, err);
        check_value("mstatus", data, (32'd1 << `MSTATUS_MPIE) | (32'd3 << MPP_LSB));
        check_value("priv_level", {30'd0, priv_level}, 32'd3);
        report_test("exception_priority");
    endtask

    task automatic environment_call;
        logic [31:0] data;
        logic [31:0] old_mtval;
        logic        err;
        logic        seen;
        apb_read(`CSR_MTVAL, old_mtval, err);
        // mpp = U, then mret drops to user mode
        apb_write(`CSR_MSTATUS, 32'd0);
        pulse_event(10'b1 << EV_MRET, 32'h100, 32'h0, seen);
        check_value("trap on mret", {31'd0, seen}, 32'd0);
        check_value("priv_level", {30'd0, priv_level}, 32'd0);
        pulse_event(10'b1 << EV_ECALL, 32'h200, 32'hdead_0000, seen);
        check_value("trap", {31'd0, seen}, 32'd1);
        apb_read(`CSR_MCAUSE, data, err);
        check_value("mcause", data, {28'd0, `EX_ENV_U});
        check_value("priv_level", {30'd0, priv_level}, 32'd3);
        pulse_event(10'b1 << EV_ECALL, 32'h204, 32'hdead_0004, seen);
        apb_read(`CSR_MCAUSE, data, err);
        check_value("mcause", data, {28'd0, `EX_ENV_M});
        apb_read(`CSR_MTVAL, data, err);
        check_value("mtval", data, old_mtval);
        report_test("environment_call");
    endtask

    task automatic interrupt_delivery;
        logic [31:0] data;
        logic        err;
        apb_write(`CSR_MIE, (32'd1 << `MIP_MEIP) | (32'd1 << `MIP_MTIP));
        apb_write(`CSR_MSTATUS, 32'd1 << `MSTATUS_MIE);
        pulse_irq((6'b1 << IRQ_EXT) | (6'b1 << IRQ_TIMER));
        wait_trap(3, "external interrupt");
        apb_read(`CSR_MIP, data, err);
        check_value("mip", data, (32'd1 << `MIP_MEIP) | (32'd1 << `MIP_MTIP));
        apb_read(`CSR_MCAUSE, data, err);
        check_value("mcause", data, {1'b1, 27'd0, `INT_EXT_M});
        apb_read(`CSR_MSTATUS, data, err);
        check_value("mstatus.mie", {31'd0, data[`MSTATUS_MIE]}, 32'd0);
        pulse_irq(6'b1 << IRQ_CLR_EXT);
        apb_read(`CSR_MIP, data, err);
        check_value("mip", data, 32'd1 << `MIP_MTIP);
        report_test("interrupt_delivery");
    endtask

    task automatic interrupt_masking;
        logic [31:0] data;
        logic        err;
        int          trap_cycles;
        trap_cycles = 0;
        // Timer is pending and enabled, only mstatus.mie holds it off
        repeat (20) begin
            @(negedge CLK);
            if (trap)
                trap_cycles++;
        end
        check_value("trap cycles while masked", trap_cycles, 32'd0);
        apb_write(`CSR_MSTATUS, 32'd1 << `MSTATUS_MIE);
        wait_trap(3, "timer interrupt");
        apb_read(`CSR_MCAUSE, data, err);
        check_value("mcause", data, {1'b1, 27'd0, `INT_TIMER_M});
        pulse_irq(6'b1 << IRQ_CLR_TIMER);
        report_test("interrupt_masking");
    endtask

    task automatic mret_return;
        logic [31:0] data;
        logic        err;
        logic        seen;
        logic [31:0] pc;
        pc = $random(seed);
        apb_write(`CSR_MSTATUS, 32'd0);
        pulse_event(10'b1 << EV_MRET, 32'h0, 32'h0, seen);
        check_value("priv_level", {30'd0, priv_level}, 32'd0);
        apb_write(`CSR_MSTATUS, 32'd1 << `MSTATUS_MIE);
        pulse_event(10'b1 << EV_BREAKPOINT, pc, 32'h0, seen);
        check_value("trap", {31'd0, seen}, 32'd1);
        check_value("priv_level", {30'd0, priv_level}, 32'd3);
        apb_read(`CSR_MSTATUS, data, err);
        check_value("mstatus", data, 32'd1 << `MSTATUS_MPIE);
        check_value("mret_target", mret_target, pc);
        pulse_event(10'b1 << EV_MRET, 32'h0, 32'h0, seen);
        check_value("trap on mret", {31'd0, seen}, 32'd0);
        apb_read(`CSR_MSTATUS, data, err);
        check_value("mstatus", data, 32'd1 << `MSTATUS_MIE);
        check_value("priv_level", {30'd0, priv_level}, 32'd0);
        check_value("mret_target", mret_target, pc);
        report_test("mret_return");
    endtask

    initial begin
        seed        = 32'ha691_e4eb;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        cycles      = 0;
        rst_n       = 1'b0;
        events      = '0;
        irq_lines   = '0;
        epc         = '0;
        badaddr     = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        repeat (2) @(posedge CLK);
        rst_n <= 1'b1;
        reset_and_apb();
        exception_priority();
        environment_call();
        interrupt_delivery();
        interrupt_masking();
        mret_return();
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/priv_pkg.sv
rtl/priv_int_ex_handler.sv
rtl/priv_csr_regs.sv
rtl/priv_trap_unit.sv
test/priv_trap_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the trap unit testbench with Verilator, run it, and scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module priv_trap_unit_tb -f all.f -o trap_sim \
    && ./obj_dir/trap_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
